//--- rtl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// logical word seen on the bus
`define WORD_W        32
`define N_LANES       4

// physical macro geometry
`define MACRO_W       64
`define MACRO_ROWS_W  8

// bank split of the word address
`define BANK_SEL_W    2
`define N_BANKS       4
`define ADDR_W        10

// apb byte address
`define PADDR_W       12

`endif

//--- rtl/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // one request per cycle at most, valid for a single clock
  typedef struct packed {
    logic                     valid;
    mem_op_e                  op;
    logic [`BANK_SEL_W-1:0]   bank;
    logic [`MACRO_ROWS_W-1:0] row;
    logic [`WORD_W-1:0]       wdata;
    logic [`N_LANES-1:0]      wmask;
  } mem_req_t;

  // read return, already truncated to the word width
  typedef struct packed {
    logic               valid;
    logic [`WORD_W-1:0] rdata;
  } mem_rsp_t;

endpackage

//--- rtl/apb_pkg.sv
`include "mem_params.svh"

package apb_pkg;

  // master side of the bus
  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [`PADDR_W-1:0] paddr;
    logic [`WORD_W-1:0]  pwdata;
    logic [`N_LANES-1:0] pstrb;
  } apb_req_t;

  // slave side, no pslverr since every address hits storage
  typedef struct packed {
    logic               pready;
    logic [`WORD_W-1:0] prdata;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_access  = 2'd1,
    st_rd_wait = 2'd2
  } apb_state_e;

endpackage

//--- rtl/apb_mem_front.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module apb_mem_front (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  output mem_pkg::mem_req_t mem_req,
  input  mem_pkg::mem_rsp_t mem_rsp
);

  import apb_pkg::*;
  import mem_pkg::*;

  apb_state_e         state;
  apb_state_e         state_nxt;
  logic               setup_phase;
  logic               access_phase;
  logic [`ADDR_W-1:0] word_addr;

  assign setup_phase  = apb_req.psel && !apb_req.penable;
  assign access_phase = apb_req.psel && apb_req.penable;

  // drop the byte offset, paddr is word aligned
  assign word_addr = apb_req.paddr[`PADDR_W-1 -: `ADDR_W];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (setup_phase) begin
          state_nxt = st_access;
        end
      end
      st_access: begin
        // writes finish here, reads take one wait state
        if (access_phase) begin
          state_nxt = apb_req.pwrite ? st_idle : st_rd_wait;
        end
      end
      st_rd_wait: begin
        if (mem_rsp.valid) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // request goes out in the first access cycle only
  always_comb begin
    mem_req.valid = (state == st_access) && access_phase;
    mem_req.op    = apb_req.pwrite ? op_write : op_read;
    mem_req.bank  = word_addr[`ADDR_W-1 -: `BANK_SEL_W];
    mem_req.row   = word_addr[`MACRO_ROWS_W-1:0];
    mem_req.wdata = apb_req.pwdata;
    mem_req.wmask = apb_req.pstrb;
  end

  always_comb begin
    case (state)
      st_access: begin
        apb_rsp.pready = access_phase && apb_req.pwrite;
      end
      st_rd_wait: begin
        apb_rsp.pready = mem_rsp.valid;
      end
      default: begin
        apb_rsp.pready = 1'b0;
      end
    endcase
    // only drive read data while a read is being answered
    apb_rsp.prdata = (state == st_rd_wait) ? mem_rsp.rdata : '0;
  end

endmodule

//--- rtl/sram_macro.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module sram_macro (
  input  logic                     clk,
  input  logic                     ce_n,
  input  logic                     we_n,
  input  logic                     oe_n,
  input  logic [`MACRO_ROWS_W-1:0] addr,
  input  logic [`MACRO_W/8-1:0]    wmask,
  input  logic [`MACRO_W-1:0]      din,
  output logic [`MACRO_W-1:0]      dout
);

  logic [`MACRO_W-1:0] mem [2**`MACRO_ROWS_W];
  logic                wr_en;
  logic                rd_en;

  assign wr_en = !ce_n && !we_n;
  assign rd_en = !ce_n && !oe_n;

  // byte granular write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `MACRO_W/8; b++) begin
        if (wmask[b]) begin
          mem[addr][b*8 +: 8] <= din[b*8 +: 8];
        end
      end
    end
  end

  // idle macro drives zeros so the banks can be ORed
  always_ff @(posedge clk) begin
    if (rd_en) begin
      dout <= mem[addr];
    end else begin
      dout <= '0;
    end
  end

endmodule

//--- rtl/banked_sram.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module banked_sram (
  input  logic                clk,
  input  mem_pkg::mem_req_t   mem_req,
  output logic [`MACRO_W-1:0] bank_rdata
);

  import mem_pkg::*;

  logic                  ce_n;
  logic                  is_wr;
  logic [`MACRO_W-1:0]   din_pad;
  logic [`MACRO_W/8-1:0] wmask_pad;
  logic [`MACRO_W-1:0]   bank_dout [`N_BANKS];

  assign ce_n  = !mem_req.valid;
  assign is_wr = (mem_req.op == op_write);

  // upper half of the macro is never written
  assign din_pad   = {{(`MACRO_W - `WORD_W){1'b0}}, mem_req.wdata};
  assign wmask_pad = {{(`MACRO_W/8 - `N_LANES){1'b0}}, mem_req.wmask};

  for (genvar i = 0; i < `N_BANKS; i++) begin : g_bank
    logic sel;
    logic we_n;
    logic oe_n;

    assign sel = (mem_req.bank == `BANK_SEL_W'(i));

    // unselected banks see neither write nor output enable
    assign we_n = sel ? !is_wr : 1'b1;
    assign oe_n = sel ? is_wr : 1'b1;

    sram_macro u_macro (
      .clk   (clk),
      .ce_n  (ce_n),
      .we_n  (we_n),
      .oe_n  (oe_n),
      .addr  (mem_req.row),
      .wmask (wmask_pad),
      .din   (din_pad),
      .dout  (bank_dout[i])
    );
  end

  // at most one bank returns nonzero data
  always_comb begin
    bank_rdata = '0;
    for (int b = 0; b < `N_BANKS; b++) begin
      bank_rdata = bank_rdata | bank_dout[b];
    end
  end

endmodule

//--- rtl/rd_return.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module rd_return (
  input  logic                clk,
  input  logic                rst_n,
  input  mem_pkg::mem_req_t   mem_req,
  input  logic [`MACRO_W-1:0] bank_rdata,
  output mem_pkg::mem_rsp_t   mem_rsp
);

  import mem_pkg::*;

  logic rd_issued;
  logic rd_pend;

  assign rd_issued = mem_req.valid && (mem_req.op == op_read);

  // macro output lands one clock after the request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= rd_issued;
    end
  end

  always_comb begin
    mem_rsp.valid = rd_pend;
    // drop the padding half
    mem_rsp.rdata = bank_rdata[`WORD_W-1:0];
  end

endmodule

//--- rtl/apb_sram_top.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module apb_sram_top (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp
);

  import mem_pkg::*;

  mem_req_t            mem_req;
  mem_rsp_t            mem_rsp;
  logic [`MACRO_W-1:0] bank_rdata;

  // bus side, produces one request per transfer
  apb_mem_front u_front (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  banked_sram u_banks (
    .clk        (clk),
    .mem_req    (mem_req),
    .bank_rdata (bank_rdata)
  );

  // read data back to the front
  rd_return u_ret (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_req    (mem_req),
    .bank_rdata (bank_rdata),
    .mem_rsp    (mem_rsp)
  );

endmodule

//--- verif/tb_apb_sram.sv
`timescale 1ns/10ps
`include "mem_params.svh"

module tb_apb_sram;

  import apb_pkg::*;

  localparam int PREADY_TIMEOUT = 20;
  localparam int N_RANDOM       = 200;
  localparam int N_WORDS        = 1 << `ADDR_W;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  // reference image of the word array
  logic [`WORD_W-1:0]  model [N_WORDS];
  // known marks the bytes written so far
  logic [`N_LANES-1:0] known [N_WORDS];
  logic [`ADDR_W-1:0]  written [$];

  int     checks;
  int     mismatches;
  int     timing_errs;
  int     timeouts;
  int     other_errs;
  integer seed;

  apb_sram_top uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // low two bits of paddr are the byte offset
  function automatic logic [`ADDR_W-1:0] word_of(input logic [`PADDR_W-1:0] paddr);
    return paddr[`PADDR_W-1 -: `ADDR_W];
  endfunction

  task automatic update_model(input logic [`ADDR_W-1:0] w, input logic [`WORD_W-1:0] data,
                              input logic [`N_LANES-1:0] strb);
    for (int l = 0; l < `N_LANES; l++) begin
      if (strb[l]) begin
        model[w][l*8 +: 8] = data[l*8 +: 8];
        known[w][l] = 1'b1;
      end
    end
  endtask

  task automatic check_pready_low(input string name);
    checks++;
    if (apb_rsp.pready !== 1'b0) begin
      $display("FAIL %s: expected pready 0, actual %b", name, apb_rsp.pready);
      mismatches++;
    end
  endtask

  task automatic compare_word(input string name, input logic [`WORD_W-1:0] exp,
                              input logic [`WORD_W-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  // waits counts access cycles without pready
  task automatic apb_transfer(input logic wr, input logic [`PADDR_W-1:0] addr,
                              input logic [`WORD_W-1:0] wdata, input logic [`N_LANES-1:0] strb,
                              output logic [`WORD_W-1:0] rdata, output int waits,
                              output logic ok);
    apb_req_t req;
    int       cycles;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = wr;
    req.paddr   = addr;
    req.pwdata  = wdata;
    req.pstrb   = strb;
    @(posedge clk);
    apb_req <= req;
    @(posedge clk);
    req.penable = 1'b1;
    apb_req <= req;
    waits  = 0;
    cycles = 0;
    ok     = 1'b0;
    rdata  = '0;
    while (!ok && cycles < PREADY_TIMEOUT) begin
      @(negedge clk);
      if (apb_rsp.pready === 1'b1) begin
        ok    = 1'b1;
        rdata = apb_rsp.prdata;
      end else begin
        waits = waits + 1;
      end
      cycles++;
    end
    if (!ok) begin
      $display("timeout: no pready within %0d cycles for paddr %h", PREADY_TIMEOUT, addr);
      timeouts++;
    end
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic write_word(input logic [`PADDR_W-1:0] addr, input logic [`WORD_W-1:0] data,
                            input logic [`N_LANES-1:0] strb, input string name);
    logic [`WORD_W-1:0] rd_ignored;
    int                 waits;
    logic               ok;
    apb_transfer(1'b1, addr, data, strb, rd_ignored, waits, ok);
    if (ok) begin
      checks++;
      // zero wait states on writes
      if (waits != 0) begin
        $display("FAIL %s write wait states: expected 0, actual %0d", name, waits);
        timing_errs++;
      end
      update_model(word_of(addr), data, strb);
    end
  endtask

  task automatic read_word(input logic [`PADDR_W-1:0] addr, output logic [`WORD_W-1:0] data,
                           output logic ok, input string name);
    int waits;
    apb_transfer(1'b0, addr, '0, '0, data, waits, ok);
    if (ok) begin
      checks++;
      if (waits != 1) begin
        $display("FAIL %s read wait states: expected 1, actual %0d", name, waits);
        timing_errs++;
      end
    end
  endtask

  task automatic replay_vectors;
    int                  fd;
    int                  lineno;
    int                  n;
    int                  op;
    string               line;
    string               name;
    logic [`PADDR_W-1:0] paddr;
    logic [`WORD_W-1:0]  wdata;
    logic [`WORD_W-1:0]  exp;
    logic [`WORD_W-1:0]  rdata;
    logic [`N_LANES-1:0] strb;
    logic                ok;
    fd = $fopen("verif/apb_sram_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file verif/apb_sram_vectors.txt");
      other_errs++;
      return;
    end
    lineno = 0;
    while ($fgets(line, fd) != 0) begin
      lineno++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h", op, paddr, wdata, strb, exp);
      if (n != 5) begin
        $display("vector line %0d could not be parsed", lineno);
        other_errs++;
        continue;
      end
      name = $sformatf("vector line %0d", lineno);
      if (op != 0) begin
        write_word(paddr, wdata, strb, name);
      end else begin
        read_word(paddr, rdata, ok, name);
        if (ok) begin
          compare_word(name, exp, rdata);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic random_phase;
    logic [31:0]         rnd;
    logic [`WORD_W-1:0]  data;
    logic [`WORD_W-1:0]  rdata;
    logic [`ADDR_W-1:0]  waddr;
    logic [`N_LANES-1:0] strb;
    int                  idx;
    logic                ok;
    string               name;
    for (int i = 0; i < N_RANDOM; i++) begin
      name  = $sformatf("random %0d", i);
      rnd   = $random(seed);
      waddr = rnd[`ADDR_W-1:0];
      strb  = rnd[16 +: `N_LANES];
      // first write to a word fills every lane
      if (known[waddr] == '0) begin
        strb = '1;
      end
      data  = $random(seed);
      write_word({waddr, 2'b00}, data, strb, name);
      written.push_back(waddr);
      // read back any word touched so far
      rnd   = $random(seed);
      idx   = int'(rnd[15:0]) % written.size();
      waddr = written[idx];
      read_word({waddr, 2'b00}, rdata, ok, name);
      if (ok) begin
        compare_word(name, model[waddr], rdata);
      end
    end
  endtask

  initial begin
    int total;
    seed        = 32'h0186244a;
    checks      = 0;
    mismatches  = 0;
    timing_errs = 0;
    timeouts    = 0;
    other_errs  = 0;
    rst_n       = 1'b0;
    apb_req     = '0;
    for (int w = 0; w < N_WORDS; w++) begin
      model[w] = '0;
      known[w] = '0;
    end

    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i < 15) begin
        @(negedge clk);
        check_pready_low("pready during reset");
      end
    end
    rst_n <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_pready_low("pready after reset");
    end

    replay_vectors();
    random_phase();
    repeat (2) @(posedge clk);

    total = mismatches + timing_errs + timeouts + other_errs;
    $display("checks %0d, errors %0d: mismatches %0d, timing %0d, timeouts %0d, other %0d",
             checks, total, mismatches, timing_errs, timeouts, other_errs);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verif/apb_sram_vectors.txt
# op (1 write, 0 read)  paddr  wdata  pstrb  expected rdata, all hex
# writes ignore the last column, reads ignore wdata and pstrb
# full write then read back
1 004 12345678 f 00000000
0 004 00000000 0 12345678
1 3f8 cafef00d f 00000000
0 3f8 00000000 0 cafef00d
# single byte lanes merge into one word
1 010 00000000 f 00000000
1 010 000000aa 1 00000000
1 010 0000bb00 2 00000000
1 010 00cc0000 4 00000000
1 010 dd000000 8 00000000
0 010 00000000 0 ddccbbaa
1 010 ffffff11 1 00000000
0 010 00000000 0 ddccbb11
# row 05 in each of the four banks
1 014 a0a0a0a0 f 00000000
1 414 b1b1b1b1 f 00000000
1 814 c2c2c2c2 f 00000000
1 c14 d3d3d3d3 f 00000000
0 014 00000000 0 a0a0a0a0
0 414 00000000 0 b1b1b1b1
0 814 00000000 0 c2c2c2c2
0 c14 00000000 0 d3d3d3d3
# all ones must not pick up the upper macro half
1 ffc ffffffff f 00000000
0 ffc 00000000 0 ffffffff
1 bfc 00000000 f 00000000
0 bfc 00000000 0 00000000
0 ffc 00000000 0 ffffffff

//--- src.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/apb_pkg.sv
rtl/apb_mem_front.sv
rtl/sram_macro.sv
rtl/banked_sram.sv
rtl/rd_return.sv
rtl/apb_sram_top.sv
verif/tb_apb_sram.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_apb_sram -f src.f || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_apb_sram)
echo "$out"

echo "$out" | grep -qx "All checks passed" && echo "simulation passed" && exit 0 ||
  { echo "simulation failed"; exit 1; }
